/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timescale 1ns/1ps
TOP       = controllerTb
FILELIST  = filelist.f
PASS_MSG  = Regression passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

/* design/aluOpDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module aluOpDecoder
    import rvIsaPkg::*;
    import ctrlPkg::*;
(
    input  instrClassT instrClass,
    input  funct3T     funct3,
    input  logic       funct7Alt,
    output aluOpT      aluOp,
    output logic       aluSrc,
    output logic       aSel
);

    logic isReg;

    assign isReg = (instrClass == CLS_REG);

    always_comb begin
        aluOp  = ALU_ADD;
        aluSrc = 1'b0;
        aSel   = 1'b0;
        case (instrClass)
            CLS_REG, CLS_IMM: begin
                aluSrc = !isReg;   // immediate as operand b
                case (funct3)
                    F3_ADD:  aluOp = (isReg && funct7Alt) ? ALU_SUB : ALU_ADD;
                    F3_SLL:  aluOp = ALU_SLL;
                    F3_SLT:  aluOp = ALU_SLT;
                    F3_SLTU: aluOp = ALU_SLTU;
                    F3_XOR:  aluOp = ALU_XOR;
                    F3_SR:   aluOp = funct7Alt ? ALU_SRA : ALU_SRL;
                    F3_OR:   aluOp = ALU_OR;
                    F3_AND:  aluOp = ALU_AND;
                    default: aluOp = ALU_ADD;
                endcase
            end
            CLS_LUI: begin
                aluOp  = ALU_LUI;
                aluSrc = 1'b1;
            end
            CLS_LOAD, CLS_STORE, CLS_JALR: begin
                aluSrc = 1'b1;   // address or target = rs1 + imm
            end
            CLS_BRANCH, CLS_JAL: begin
                aluSrc = 1'b1;
                aSel   = 1'b1;   // target = pc + imm
            end
            default: begin
                aluOp  = ALU_ADD;
                aluSrc = 1'b0;
                aSel   = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* design/branchResolver.sv */
`timescale 1ns/1ps
`default_nettype none

module branchResolver
    import rvIsaPkg::*;
    import ctrlPkg::*;
(
    input  instrClassT instrClass,
    input  funct3T     funct3,
    input  logic       brEq,
    input  logic       brLt,
    output logic       pcSel,
    output logic       branchUnsigned
);

    always_comb begin
        pcSel          = 1'b0;
        branchUnsigned = 1'b0;
        case (instrClass)
            CLS_BRANCH: begin
                // comparator sees this in the same cycle
                branchUnsigned = (funct3 == F3_BLTU) || (funct3 == F3_BGEU);
                case (funct3)
                    F3_BEQ:          pcSel = brEq;
                    F3_BNE:          pcSel = !brEq;
                    F3_BLT, F3_BLTU: pcSel = brLt;
                    F3_BGE, F3_BGEU: pcSel = !brLt;
                    default:         pcSel = 1'b0;
                endcase
            end
            CLS_JAL, CLS_JALR: begin
                pcSel = 1'b1;   // unconditional
            end
            default: begin
                pcSel          = 1'b0;
                branchUnsigned = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* design/controller.sv */
`timescale 1ns/1ps
`default_nettype none

module controller
    import rvIsaPkg::*;
    import ctrlPkg::*;
(
    input  instrT  instr,
    input  logic   brEq,
    input  logic   brLt,
    output logic   pcSel,
    output logic   branchUnsigned,
    output logic   aSel,
    output logic   aluSrc,
    output aluOpT  aluOp,
    output logic   regWrite,
    output wbSelT  wbSel,
    output logic   memRead,
    output logic   memWrite,
    output logic   stByte,
    output logic   stHalf,
    output logic   ldByte,
    output logic   ldHalf,
    output logic   loadUnsigned
);

    opcodeT     opcode;
    funct3T     funct3;
    funct7T     funct7;
    logic       funct7Alt;
    instrClassT instrClass;

    assign opcode    = instr[OPCODE_W-1:0];
    assign funct3    = instr[FUNCT3_LSB +: FUNCT3_W];
    assign funct7    = instr[FUNCT7_LSB +: FUNCT7_W];
    assign funct7Alt = instr[ALT_BIT];

    instrClassDecoder classDecoder_i (
        .opcode     (opcode),
        .funct3     (funct3),
        .funct7     (funct7),
        .instrClass (instrClass),
        .regWrite   (regWrite),
        .wbSel      (wbSel)
    );

    aluOpDecoder aluDecoder_i (
        .instrClass (instrClass),
        .funct3     (funct3),
        .funct7Alt  (funct7Alt),
        .aluOp      (aluOp),
        .aluSrc     (aluSrc),
        .aSel       (aSel)
    );

    memAccessDecoder memDecoder_i (
        .instrClass   (instrClass),
        .funct3       (funct3),
        .memRead      (memRead),
        .memWrite     (memWrite),
        .stByte       (stByte),
        .stHalf       (stHalf),
        .ldByte       (ldByte),
        .ldHalf       (ldHalf),
        .loadUnsigned (loadUnsigned)
    );

    branchResolver branch_i (
        .instrClass     (instrClass),
        .funct3         (funct3),
        .brEq           (brEq),
        .brLt           (brLt),
        .pcSel          (pcSel),
        .branchUnsigned (branchUnsigned)
    );

endmodule

`default_nettype wire

/* design/ctrlPkg.sv */
`default_nettype none

package ctrlPkg;

    localparam int ALU_OP_W = 4;
    localparam int WB_SEL_W = 2;
    localparam int CLASS_W  = 4;

    typedef logic [ALU_OP_W-1:0] aluOpT;
    typedef logic [WB_SEL_W-1:0] wbSelT;
    typedef logic [CLASS_W-1:0]  instrClassT;

    localparam aluOpT ALU_ADD  = 4'd0;
    localparam aluOpT ALU_SUB  = 4'd1;
    localparam aluOpT ALU_OR   = 4'd2;
    localparam aluOpT ALU_AND  = 4'd3;
    localparam aluOpT ALU_XOR  = 4'd4;
    localparam aluOpT ALU_SLL  = 4'd5;
    localparam aluOpT ALU_SRL  = 4'd6;
    localparam aluOpT ALU_SRA  = 4'd7;
    localparam aluOpT ALU_SLT  = 4'd8;
    localparam aluOpT ALU_SLTU = 4'd9;
    localparam aluOpT ALU_LUI  = 4'd10;   // pass immediate through

    localparam wbSelT WB_ALU = 2'd0;
    localparam wbSelT WB_MEM = 2'd1;
    localparam wbSelT WB_PC  = 2'd2;   // link address

    localparam instrClassT CLS_ILLEGAL = 4'd0;
    localparam instrClassT CLS_REG     = 4'd1;
    localparam instrClassT CLS_IMM     = 4'd2;
    localparam instrClassT CLS_LOAD    = 4'd3;
    localparam instrClassT CLS_STORE   = 4'd4;
    localparam instrClassT CLS_BRANCH  = 4'd5;
    localparam instrClassT CLS_JAL     = 4'd6;
    localparam instrClassT CLS_JALR    = 4'd7;
    localparam instrClassT CLS_LUI     = 4'd8;

endpackage

`default_nettype wire

/* design/instrClassDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instrClassDecoder
    import rvIsaPkg::*;
    import ctrlPkg::*;
(
    input  opcodeT     opcode,
    input  funct3T     funct3,
    input  funct7T     funct7,
    output instrClassT instrClass,
    output logic       regWrite,
    output wbSelT      wbSel
);

    logic funct7Ok;   // base or alt encoding only
    logic shiftOrAdd;

    assign funct7Ok   = (funct7 == F7_BASE) || (funct7 == F7_ALT);
    assign shiftOrAdd = (funct3 == F3_ADD) || (funct3 == F3_SR);

    always_comb begin
        instrClass = CLS_ILLEGAL;
        case (opcode)
            OP_REG: begin
                if (!shiftOrAdd || funct7Ok) begin
                    instrClass = CLS_REG;
                end
            end
            OP_IMM: begin
                if (funct3 != F3_SR || funct7Ok) begin   // shamt upper bits checked
                    instrClass = CLS_IMM;
                end
            end
            OP_LOAD: begin
                case (funct3)
                    F3_B, F3_H, F3_W, F3_BU, F3_HU: instrClass = CLS_LOAD;
                    default: instrClass = CLS_ILLEGAL;
                endcase
            end
            OP_STORE: begin
                case (funct3)
                    F3_B, F3_H, F3_W: instrClass = CLS_STORE;
                    default: instrClass = CLS_ILLEGAL;
                endcase
            end
            OP_BRANCH: begin
                case (funct3)
                    F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU: begin
                        instrClass = CLS_BRANCH;
                    end
                    default: instrClass = CLS_ILLEGAL;
                endcase
            end
            OP_JALR: begin
                if (funct3 == 3'b000) begin
                    instrClass = CLS_JALR;
                end
            end
            OP_JAL: instrClass = CLS_JAL;
            OP_LUI: instrClass = CLS_LUI;
            default: instrClass = CLS_ILLEGAL;   // auipc, fence, system
        endcase
    end

    always_comb begin
        regWrite = 1'b0;
        wbSel    = WB_ALU;
        case (instrClass)
            CLS_REG, CLS_IMM, CLS_LUI: begin
                regWrite = 1'b1;
            end
            CLS_LOAD: begin
                regWrite = 1'b1;
                wbSel    = WB_MEM;
            end
            CLS_JAL, CLS_JALR: begin
                regWrite = 1'b1;
                wbSel    = WB_PC;
            end
            default: begin
                regWrite = 1'b0;   // stores, branches, illegal
                wbSel    = WB_ALU;
            end
        endcase
    end

endmodule

`default_nettype wire

/* design/memAccessDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module memAccessDecoder
    import rvIsaPkg::*;
    import ctrlPkg::*;
(
    input  instrClassT instrClass,
    input  funct3T     funct3,
    output logic       memRead,
    output logic       memWrite,
    output logic       stByte,
    output logic       stHalf,
    output logic       ldByte,
    output logic       ldHalf,
    output logic       loadUnsigned
);

    always_comb begin
        memRead      = 1'b0;
        memWrite     = 1'b0;
        stByte       = 1'b0;
        stHalf       = 1'b0;
        ldByte       = 1'b0;
        ldHalf       = 1'b0;
        loadUnsigned = 1'b0;
        case (instrClass)
            CLS_LOAD: begin
                memRead      = 1'b1;
                ldByte       = (funct3 == F3_B) || (funct3 == F3_BU);
                ldHalf       = (funct3 == F3_H) || (funct3 == F3_HU);
                loadUnsigned = (funct3 == F3_BU) || (funct3 == F3_HU);   // zero extend
            end
            CLS_STORE: begin
                memWrite = 1'b1;
                stByte   = (funct3 == F3_B);
                stHalf   = (funct3 == F3_H);   // word when neither set
            end
            default: begin
                memRead  = 1'b0;
                memWrite = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* design/rvIsaPkg.sv */
`default_nettype none

package rvIsaPkg;

    localparam int INSTR_W  = 32;
    localparam int OPCODE_W = 7;
    localparam int FUNCT3_W = 3;
    localparam int FUNCT7_W = 7;

    // field positions inside the instruction word
    localparam int FUNCT3_LSB = 12;
    localparam int FUNCT7_LSB = 25;
    localparam int ALT_BIT    = 30;   // sub/sra select

    typedef logic [INSTR_W-1:0]  instrT;
    typedef logic [OPCODE_W-1:0] opcodeT;
    typedef logic [FUNCT3_W-1:0] funct3T;
    typedef logic [FUNCT7_W-1:0] funct7T;

    localparam opcodeT OP_REG    = 7'b0110011;
    localparam opcodeT OP_IMM    = 7'b0010011;
    localparam opcodeT OP_LOAD   = 7'b0000011;
    localparam opcodeT OP_STORE  = 7'b0100011;
    localparam opcodeT OP_BRANCH = 7'b1100011;
    localparam opcodeT OP_JAL    = 7'b1101111;
    localparam opcodeT OP_JALR   = 7'b1100111;
    localparam opcodeT OP_LUI    = 7'b0110111;

    // alu group
    localparam funct3T F3_ADD  = 3'b000;
    localparam funct3T F3_SLL  = 3'b001;
    localparam funct3T F3_SLT  = 3'b010;
    localparam funct3T F3_SLTU = 3'b011;
    localparam funct3T F3_XOR  = 3'b100;
    localparam funct3T F3_SR   = 3'b101;   // srl or sra
    localparam funct3T F3_OR   = 3'b110;
    localparam funct3T F3_AND  = 3'b111;

    // load and store widths
    localparam funct3T F3_B  = 3'b000;
    localparam funct3T F3_H  = 3'b001;
    localparam funct3T F3_W  = 3'b010;
    localparam funct3T F3_BU = 3'b100;
    localparam funct3T F3_HU = 3'b101;

    // branch conditions
    localparam funct3T F3_BEQ  = 3'b000;
    localparam funct3T F3_BNE  = 3'b001;
    localparam funct3T F3_BLT  = 3'b100;
    localparam funct3T F3_BGE  = 3'b101;
    localparam funct3T F3_BLTU = 3'b110;
    localparam funct3T F3_BGEU = 3'b111;

    localparam funct7T F7_BASE = 7'b0000000;
    localparam funct7T F7_ALT  = 7'b0100000;

endpackage

`default_nettype wire

/* filelist.f */
+incdir+sim
design/rvIsaPkg.sv
design/ctrlPkg.sv
design/instrClassDecoder.sv
design/aluOpDecoder.sv
design/memAccessDecoder.sv
design/branchResolver.sv
design/controller.sv
sim/controllerTb.sv

/* sim/controllerRef.svh */
`ifndef CONTROLLER_REF_SVH
`define CONTROLLER_REF_SVH

// expected control word, one field per controller output
typedef struct packed {
    logic  pcSel;
    logic  branchUnsigned;
    logic  aSel;
    logic  aluSrc;
    aluOpT aluOp;
    logic  regWrite;
    wbSelT wbSel;
    logic  memRead;
    logic  memWrite;
    logic  stByte;
    logic  stHalf;
    logic  ldByte;
    logic  ldHalf;
    logic  loadUnsigned;
} ctrlWordT;

function automatic ctrlWordT refControl(input instrT ins, input logic eq, input logic lt);
    opcodeT   op;
    funct3T   f3;
    logic     f7Legal;
    logic     aluLegal;
    ctrlWordT r;
    op       = ins[6:0];
    f3       = ins[14:12];
    f7Legal  = (ins[31:25] == F7_BASE) || (ins[31:25] == F7_ALT);
    aluLegal = f7Legal || (f3 != F3_SR && (op == OP_IMM || f3 != F3_ADD));
    r        = '0;   // illegal word
    case (op)
        OP_REG, OP_IMM: begin
            if (aluLegal) begin
                r.regWrite = 1'b1;
                r.aluSrc   = (op == OP_IMM);
                case (f3)
                    F3_ADD:  r.aluOp = (op == OP_REG && ins[30]) ? ALU_SUB : ALU_ADD;
                    F3_SLL:  r.aluOp = ALU_SLL;
                    F3_SLT:  r.aluOp = ALU_SLT;
                    F3_SLTU: r.aluOp = ALU_SLTU;
                    F3_XOR:  r.aluOp = ALU_XOR;
                    F3_SR:   r.aluOp = ins[30] ? ALU_SRA : ALU_SRL;
                    F3_OR:   r.aluOp = ALU_OR;
                    default: r.aluOp = ALU_AND;
                endcase
            end
        end
        OP_LOAD: begin
            if (f3 != 3'b011 && f3[2:1] != 2'b11) begin   // 011, 110, 111 reserved
                r.regWrite     = 1'b1;
                r.wbSel        = WB_MEM;
                r.memRead      = 1'b1;
                r.aluSrc       = 1'b1;
                r.ldByte       = (f3[1:0] == 2'b00);
                r.ldHalf       = (f3[1:0] == 2'b01);
                r.loadUnsigned = f3[2];
            end
        end
        OP_STORE: begin
            if (!f3[2] && f3 != 3'b011) begin
                r.memWrite = 1'b1;
                r.aluSrc   = 1'b1;
                r.stByte   = (f3 == 3'b000);
                r.stHalf   = (f3 == 3'b001);
            end
        end
        OP_BRANCH: begin
            if (f3[2:1] != 2'b01) begin
                r.aluSrc         = 1'b1;
                r.aSel           = 1'b1;
                r.branchUnsigned = (f3[2:1] == 2'b11);   // bltu, bgeu
                case (f3)
                    F3_BEQ:          r.pcSel = eq;
                    F3_BNE:          r.pcSel = !eq;
                    F3_BLT, F3_BLTU: r.pcSel = lt;
                    default:         r.pcSel = !lt;
                endcase
            end
        end
        OP_JAL: begin
            r.regWrite = 1'b1;
            r.wbSel    = WB_PC;
            r.pcSel    = 1'b1;
            r.aluSrc   = 1'b1;
            r.aSel     = 1'b1;
        end
        OP_JALR: begin
            if (f3 == 3'b000) begin
                r.regWrite = 1'b1;
                r.wbSel    = WB_PC;
                r.pcSel    = 1'b1;
                r.aluSrc   = 1'b1;
            end
        end
        OP_LUI: begin
            r.regWrite = 1'b1;
            r.aluOp    = ALU_LUI;
            r.aluSrc   = 1'b1;
        end
        default: r = '0;
    endcase
    return r;
endfunction

`endif

/* sim/controllerTb.sv */
`timescale 1ns/1ps
`default_nettype none

module controllerTb
    import rvIsaPkg::*;
    import ctrlPkg::*;
();

    localparam int HALF_PERIOD  = 20;
    localparam int DRIVE_DELAY  = 5;
    localparam int RESET_CYCLES = 10;
    localparam int WAIT_LIMIT   = 20;   // cycles allowed per vector
    localparam int RANDOM_COUNT = 500;

    logic   clk;
    logic   reset;
    instrT  instr;
    logic   brEq;
    logic   brLt;
    logic   pcSel;
    logic   branchUnsigned;
    logic   aSel;
    logic   aluSrc;
    aluOpT  aluOp;
    logic   regWrite;
    wbSelT  wbSel;
    logic   memRead;
    logic   memWrite;
    logic   stByte;
    logic   stHalf;
    logic   ldByte;
    logic   ldHalf;
    logic   loadUnsigned;

    int     reqCount = 0;
    int     ackCount = 0;
    int     errCount = 0;
    int     testErrStart;
    int     testVectors;
    int     testsOk;
    int     testsBad;
    integer seed;
    string  testName;

    `include "controllerRef.svh"

    ctrlWordT expected;

    controller dut_i (
        .instr          (instr),
        .brEq           (brEq),
        .brLt           (brLt),
        .pcSel          (pcSel),
        .branchUnsigned (branchUnsigned),
        .aSel           (aSel),
        .aluSrc         (aluSrc),
        .aluOp          (aluOp),
        .regWrite       (regWrite),
        .wbSel          (wbSel),
        .memRead        (memRead),
        .memWrite       (memWrite),
        .stByte         (stByte),
        .stHalf         (stHalf),
        .ldByte         (ldByte),
        .ldHalf         (ldHalf),
        .loadUnsigned   (loadUnsigned)
    );

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    task automatic checkValue(input string field, input logic [31:0] want,
                              input logic [31:0] got);
        if (want !== got) begin
            $display("ERR %0t: %s expected %0h got %0h for instr %h", $time, field, want, got,
                     instr);
            errCount++;
        end
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (ackCount != reqCount) begin
            expected = refControl(instr, brEq, brLt);
            checkValue("pcSel", 32'(expected.pcSel), 32'(pcSel));
            checkValue("branchUnsigned", 32'(expected.branchUnsigned), 32'(branchUnsigned));
            checkValue("aSel", 32'(expected.aSel), 32'(aSel));
            checkValue("aluSrc", 32'(expected.aluSrc), 32'(aluSrc));
            checkValue("aluOp", 32'(expected.aluOp), 32'(aluOp));
            checkValue("regWrite", 32'(expected.regWrite), 32'(regWrite));
            checkValue("wbSel", 32'(expected.wbSel), 32'(wbSel));
            checkValue("memRead", 32'(expected.memRead), 32'(memRead));
            checkValue("memWrite", 32'(expected.memWrite), 32'(memWrite));
            checkValue("stByte", 32'(expected.stByte), 32'(stByte));
            checkValue("stHalf", 32'(expected.stHalf), 32'(stHalf));
            checkValue("ldByte", 32'(expected.ldByte), 32'(ldByte));
            checkValue("ldHalf", 32'(expected.ldHalf), 32'(ldHalf));
            checkValue("loadUnsigned", 32'(expected.loadUnsigned), 32'(loadUnsigned));
            ackCount = reqCount;
        end
    end

    function automatic instrT makeInstr(input opcodeT op, input funct3T f3, input funct7T f7);
        return {f7, 5'd7, 5'd6, f3, 5'd5, op};   // rs2 7, rs1 6, rd 5
    endfunction

    task automatic applyVector(input instrT ins, input logic [1:0] flags);
        int waited;
        @(posedge clk);
        #DRIVE_DELAY;
        instr = ins;
        brEq  = flags[0];
        brLt  = flags[1];
        reqCount++;
        testVectors++;
        waited = 0;
        while (ackCount != reqCount && waited < WAIT_LIMIT) begin
            @(negedge clk);
            #1;
            waited++;
        end
        if (ackCount != reqCount) begin
            $display("timeout: vector %0d was not compared within %0d cycles", reqCount,
                     WAIT_LIMIT);
            $display("Regression failed");
            $finish;
        end
    endtask

    task automatic beginTest(input string name);
        testName     = name;
        testErrStart = errCount;
        testVectors  = 0;
    endtask

    task automatic finishTest();
        if (errCount == testErrStart) begin
            testsOk++;
            $display("test %-10s ok, %0d vectors", testName, testVectors);
        end else begin
            testsBad++;
            $display("test %-10s has %0d mismatches over %0d vectors", testName,
                     errCount - testErrStart, testVectors);
        end
    endtask

    initial begin
        int          f;
        int          fl;
        int          n;
        logic [31:0] word;
        logic [31:0] flagWord;
        opcodeT      oddOps [5];
        reset    = 1'b1;
        instr    = '0;
        brEq     = 1'b0;
        brLt     = 1'b0;
        testsOk  = 0;
        testsBad = 0;
        seed     = 63992;
        oddOps   = '{7'b0010111, 7'b0001111, 7'b1110011, 7'b0000000, 7'b1111111};
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY reset = 1'b0;

        beginTest("reg");
        for (f = 0; f < 8; f++) begin
            applyVector(makeInstr(OP_REG, funct3T'(f), F7_BASE), 2'b00);
            applyVector(makeInstr(OP_REG, funct3T'(f), F7_ALT), 2'b11);
        end
        applyVector(makeInstr(OP_REG, F3_ADD, 7'b0000001), 2'b00);
        applyVector(makeInstr(OP_REG, F3_SR, 7'b1000000), 2'b00);
        applyVector(makeInstr(OP_REG, F3_XOR, 7'b0000001), 2'b00);   // funct7 ignored
        finishTest();

        beginTest("imm");
        for (f = 0; f < 8; f++) begin
            applyVector(makeInstr(OP_IMM, funct3T'(f), F7_BASE), 2'b00);
        end
        applyVector(makeInstr(OP_IMM, F3_SR, F7_ALT), 2'b00);
        applyVector(makeInstr(OP_IMM, F3_ADD, F7_ALT), 2'b00);
        applyVector(makeInstr(OP_IMM, F3_ADD, 7'h7f), 2'b00);
        applyVector(makeInstr(OP_IMM, F3_SR, 7'b0000001), 2'b00);
        finishTest();

        beginTest("mem");
        for (f = 0; f < 8; f++) begin
            applyVector(makeInstr(OP_LOAD, funct3T'(f), 7'h15), 2'b00);
            applyVector(makeInstr(OP_STORE, funct3T'(f), 7'h2a), 2'b00);
        end
        finishTest();

        beginTest("branch");
        for (f = 0; f < 8; f++) begin
            for (fl = 0; fl < 4; fl++) begin
                applyVector(makeInstr(OP_BRANCH, funct3T'(f), 7'h2a), 2'(fl));
            end
        end
        finishTest();

        beginTest("jump/lui");
        applyVector(makeInstr(OP_JAL, 3'b101, 7'h33), 2'b00);
        for (f = 0; f < 8; f++) begin
            applyVector(makeInstr(OP_JALR, funct3T'(f), 7'h01), 2'b10);
        end
        applyVector(makeInstr(OP_LUI, 3'b011, 7'h7f), 2'b01);
        for (f = 0; f < 5; f++) begin
            applyVector(makeInstr(oddOps[f], 3'b000, F7_BASE), 2'b00);
        end
        finishTest();

        beginTest("random");
        for (n = 0; n < RANDOM_COUNT; n++) begin
            word     = $random(seed);
            flagWord = $random(seed);
            applyVector(word, flagWord[1:0]);
        end
        finishTest();

        $display("summary: %0d tests ok, %0d tests with errors, %0d mismatches", testsOk,
                 testsBad, errCount);
        if (testsBad == 0 && errCount == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
